// ==== rom_pkg.sv ====
// ROM sharing package with the word types and the slot and arbiter state encodings
`default_nettype none

package rom_pkg;

    // One ROM word address
    typedef logic [15:0] rom_addr_t;

    // One ROM data word, as the SDRAM delivers it
    typedef logic [15:0] rom_data_t;

    // Client fetch slot
    typedef enum logic [1:0] {
        SLOT_EMPTY = 2'd0,  // Nothing cached
        SLOT_REQ   = 2'd1,  // Miss pending at the arbiter
        SLOT_FULL  = 2'd2   // Word valid for the stored address
    } slot_state_e;

    // Memory port owner
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,    // Free, may issue a read
        ARB_READ = 2'd1,    // Waiting for read data
        ARB_LOAD = 2'd2     // Host download owns the port
    } arb_state_e;

endpackage

`default_nettype wire

// ==== rom_slot.sv ====
// Client fetch slot, a one-entry cache that asks the arbiter for a refill on a miss
`default_nettype none

module rom_slot import rom_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cs,
    input  rom_addr_t addr,
    output rom_data_t dout,
    output logic      ok,
    output logic      req,
    output rom_addr_t req_addr,
    input  logic      fill_valid,
    input  rom_data_t fill_data
);

    slot_state_e state;
    rom_addr_t   tag;      // Address of the cached or requested word
    rom_data_t   data;
    logic        miss;

    // Full slot with a different address also counts as a miss
    assign miss = cs && (state == SLOT_EMPTY || (state == SLOT_FULL && addr != tag));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SLOT_EMPTY;
            tag   <= '0;
        end else begin
            case (state)
                SLOT_EMPTY,
                SLOT_FULL: begin
                    if (miss) begin
                        tag   <= addr;  // Hold it for the arbiter
                        state <= SLOT_REQ;
                    end
                end
                SLOT_REQ: begin
                    if (fill_valid) state <= SLOT_FULL;
                end
                default: state <= SLOT_EMPTY;
            endcase
        end
    end

    // Payload word
    always_ff @(posedge clk) begin
        if (fill_valid) data <= fill_data;
    end

    assign req      = (state == SLOT_REQ);
    assign req_addr = tag;
    assign dout     = data;
    assign ok       = cs && state == SLOT_FULL && addr == tag;  // Hit in the same cycle

    // The arbiter must only answer a slot that is waiting
    a_fill_only_in_req: assert property (
        @(posedge clk) disable iff (rst) fill_valid |-> state == SLOT_REQ
    );

endmodule

`default_nettype wire

// ==== rom_arbiter.sv ====
// Round-robin arbiter of slot refills on the single memory port, download writes take over
`default_nettype none

module rom_arbiter import rom_pkg::*; #(
    parameter int N_SLOTS = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [N_SLOTS-1:0] req,
    input  rom_addr_t          req_addr [N_SLOTS],
    output logic [N_SLOTS-1:0] fill_valid,
    output rom_data_t          fill_data,
    input  logic               downloading,
    input  logic               load_wr,
    input  rom_addr_t          load_addr,
    input  rom_data_t          load_data,
    output logic               rom_ready,
    output logic               mem_rd,
    output logic               mem_wr,
    output rom_addr_t          mem_addr,
    output rom_data_t          mem_wdata,
    input  logic               mem_rvalid,
    input  rom_data_t          mem_rdata
);

    localparam int IDX_W = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1;

    arb_state_e       state, state_nx;
    logic [IDX_W-1:0] ptr;      // First lane to look at
    logic [IDX_W-1:0] grant;    // Lane whose read is in flight
    logic [IDX_W-1:0] pick;
    logic             found;
    logic             ready_q;

    // Search from ptr upwards, wrapping around
    always_comb begin
        int idx;
        pick  = ptr;
        found = 1'b0;
        for (int i = 0; i < N_SLOTS; i++) begin
            idx = (int'(ptr) + i) % N_SLOTS;
            if (!found && req[idx]) begin
                pick  = IDX_W'(idx);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            ARB_IDLE: begin
                if (downloading)  state_nx = ARB_LOAD;
                else if (found)   state_nx = ARB_READ;
            end
            ARB_READ: begin
                // Let the read drain before the host gets the port
                if (mem_rvalid) state_nx = downloading ? ARB_LOAD : ARB_IDLE;
            end
            ARB_LOAD: begin
                if (!downloading) state_nx = ARB_IDLE;
            end
            default: state_nx = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ARB_IDLE;
            ptr     <= '0;
            grant   <= '0;
            ready_q <= 1'b0;
        end else begin
            state   <= state_nx;
            ready_q <= state_nx != ARB_LOAD && !downloading;
            if (mem_rd) grant <= pick;
            if (state == ARB_READ && mem_rvalid) begin
                ptr <= (grant == IDX_W'(N_SLOTS - 1)) ? '0 : grant + IDX_W'(1);  // Next lane
            end
        end
    end

    assign mem_rd    = state == ARB_IDLE && !downloading && found;
    assign mem_wr    = downloading && load_wr && state != ARB_READ;
    assign mem_addr  = (state == ARB_READ || !downloading) ? req_addr[pick] : load_addr;
    assign mem_wdata = load_data;
    assign rom_ready = ready_q && !downloading;

    // Slots sit in reset during a download, so a late read is dropped
    always_comb begin
        fill_valid = '0;
        if (state == ARB_READ && mem_rvalid && !downloading) fill_valid[grant] = 1'b1;
    end
    assign fill_data = mem_rdata;

    // Fill goes to one lane only, and that lane still waits for it
    a_fill_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(fill_valid) && (fill_valid & ~req) == '0
    );
    // No write while read data is still coming back
    a_rd_wr_excl:  assert property (
        @(posedge clk) disable iff (rst) !(mem_wr && (mem_rd || mem_rvalid))
    );

endmodule

`default_nettype wire

// ==== rom_mem.sv ====
// ROM storage model with one write-or-read port and a fixed read latency like SDRAM CAS
`default_nettype none

module rom_mem import rom_pkg::*; #(
    parameter int RD_LATENCY = 2,
    parameter int MEM_WORDS  = 4096
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_rd,
    input  logic      mem_wr,
    input  rom_addr_t mem_addr,
    input  rom_data_t mem_wdata,
    output logic      mem_rvalid,
    output rom_data_t mem_rdata
);

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    rom_data_t             storage  [MEM_WORDS];
    logic [AW-1:0]         idx;
    logic [RD_LATENCY-1:0] vld_pipe;
    rom_data_t             dat_pipe [RD_LATENCY];

    // Addresses past the depth wrap around
    assign idx = AW'(32'(mem_addr) % MEM_WORDS);

    always_ff @(posedge clk) begin
        if (mem_wr) storage[idx] <= mem_wdata;
    end

    // Valid bit travels with the data, one stage per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= mem_rd;
            for (int i = 1; i < RD_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rd) dat_pipe[0] <= storage[idx];
        for (int i = 1; i < RD_LATENCY; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    assign mem_rvalid = vld_pipe[RD_LATENCY-1];
    assign mem_rdata  = dat_pipe[RD_LATENCY-1];

endmodule

`default_nettype wire

// ==== game_rom_top.sv ====
// Game ROM sharing top, with per-client fetch slots, the arbiter, the memory and game reset
`default_nettype none

module game_rom_top import rom_pkg::*; #(
    parameter int N_SLOTS    = 4,
    parameter int RD_LATENCY = 2,
    parameter int MEM_WORDS  = 4096
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               downloading,
    input  logic               load_wr,
    input  rom_addr_t          load_addr,
    input  rom_data_t          load_data,
    input  logic [N_SLOTS-1:0] cs,
    input  rom_addr_t          addr [N_SLOTS],
    output rom_data_t          dout [N_SLOTS],
    output logic [N_SLOTS-1:0] ok,
    output logic               rom_ready
);

    logic [1:0]         rst_chain;
    logic               rst_game;
    logic [N_SLOTS-1:0] slot_req;
    rom_addr_t          slot_addr [N_SLOTS];
    logic [N_SLOTS-1:0] fill_valid;
    rom_data_t          fill_data;
    logic               mem_rd;
    logic               mem_wr;
    rom_addr_t          mem_addr;
    rom_data_t          mem_wdata;
    logic               mem_rvalid;
    rom_data_t          mem_rdata;

    // Game stays in reset until two clocks after the download ends
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rst_chain <= 2'b11;
        end else begin
            rst_chain <= {rst_chain[0], downloading};
        end
    end

    assign rst_game = rst_chain[1] || downloading;  // Slots drop cached words at once

    for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
        rom_slot slot_i (
            .clk        ( clk           ),
            .rst        ( rst_game      ),
            .cs         ( cs[g]         ),
            .addr       ( addr[g]       ),
            .dout       ( dout[g]       ),
            .ok         ( ok[g]         ),
            .req        ( slot_req[g]   ),
            .req_addr   ( slot_addr[g]  ),
            .fill_valid ( fill_valid[g] ),
            .fill_data  ( fill_data     )
        );
    end

    rom_arbiter #(
        .N_SLOTS ( N_SLOTS )
    ) arbiter_i (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .req         ( slot_req    ),
        .req_addr    ( slot_addr   ),
        .fill_valid  ( fill_valid  ),
        .fill_data   ( fill_data   ),
        .downloading ( downloading ),
        .load_wr     ( load_wr     ),
        .load_addr   ( load_addr   ),
        .load_data   ( load_data   ),
        .rom_ready   ( rom_ready   ),
        .mem_rd      ( mem_rd      ),
        .mem_wr      ( mem_wr      ),
        .mem_addr    ( mem_addr    ),
        .mem_wdata   ( mem_wdata   ),
        .mem_rvalid  ( mem_rvalid  ),
        .mem_rdata   ( mem_rdata   )
    );

    rom_mem #(
        .RD_LATENCY ( RD_LATENCY ),
        .MEM_WORDS  ( MEM_WORDS  )
    ) mem_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .mem_rd     ( mem_rd     ),
        .mem_wr     ( mem_wr     ),
        .mem_addr   ( mem_addr   ),
        .mem_wdata  ( mem_wdata  ),
        .mem_rvalid ( mem_rvalid ),
        .mem_rdata  ( mem_rdata  )
    );

endmodule

`default_nettype wire

// ==== tb_game_rom.sv ====
// Directed testbench for the game ROM sharing top with download, single, shared and cached reads
`default_nettype none

module tb_game_rom import rom_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int        N_SLOTS    = 4;
    localparam int        RD_LATENCY = 2;
    localparam int        MEM_WORDS  = 4096;
    localparam int        TIMEOUT    = 100;       // Cycles per wait loop
    localparam rom_data_t KEY_A      = 16'hA5C3;  // First download pattern
    localparam rom_data_t KEY_B      = 16'h3C5A;  // Second download pattern

    logic               clk;
    logic               rst;
    logic               downloading;
    logic               load_wr;
    rom_addr_t          load_addr;
    rom_data_t          load_data;
    logic [N_SLOTS-1:0] cs;
    rom_addr_t          addr [N_SLOTS];
    rom_data_t          dout [N_SLOTS];
    logic [N_SLOTS-1:0] ok;
    logic               rom_ready;

    int checks;
    int errors;
    int timeouts;
    int seed = 43239;

    game_rom_top game_rom_top_i (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .load_wr     ( load_wr     ),
        .load_addr   ( load_addr   ),
        .load_data   ( load_data   ),
        .cs          ( cs          ),
        .addr        ( addr        ),
        .dout        ( dout        ),
        .ok          ( ok          ),
        .rom_ready   ( rom_ready   )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_data(input rom_data_t got, input rom_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Download rule, word is address XOR key
    function automatic rom_data_t expected_word(input rom_addr_t a, input rom_data_t key);
        expected_word = a ^ key;
    endfunction

    // Stay inside the storage depth so the address does not wrap
    function automatic rom_addr_t rand_addr();
        rand_addr = rom_addr_t'($random(seed)) & rom_addr_t'(MEM_WORDS - 1);
    endfunction

    task automatic wait_ready();
        int n = 0;
        while (rom_ready !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rom_ready !== 1'b1) begin
            timeouts++;
            $display("Timeout: rom_ready did not rise within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic do_download(input rom_data_t key);
        @(negedge clk);
        downloading = 1'b1;
        @(negedge clk);
        check_bit(rom_ready, 1'b0, "rom_ready during download");
        for (int i = 0; i < N_SLOTS; i++) begin
            check_bit(ok[i], 1'b0, $sformatf("ok[%0d] during download", i));
        end
        repeat (RD_LATENCY + 1) @(negedge clk);  // Read in flight drains first
        for (int a = 0; a < MEM_WORDS; a++) begin
            load_wr   = 1'b1;
            load_addr = rom_addr_t'(a);
            load_data = expected_word(rom_addr_t'(a), key);
            @(negedge clk);
        end
        load_wr     = 1'b0;
        downloading = 1'b0;
        wait_ready();
        repeat (2) @(negedge clk);  // Game reset chain
    endtask

    // Called at a falling edge; returns the number of cycles until ok
    task automatic read_slot(input int lane, input rom_addr_t a, input rom_data_t key,
                             input bit hold, output int lat);
        lat        = 0;
        cs[lane]   = 1'b1;
        addr[lane] = a;
        do begin
            @(negedge clk);
            lat++;
        end while (ok[lane] !== 1'b1 && lat < TIMEOUT);
        if (ok[lane] === 1'b1) begin
            check_data(dout[lane], expected_word(a, key), $sformatf("dout[%0d] at %h", lane, a));
        end else begin
            timeouts++;
            $display("Timeout: slot %0d got no ok for address %h", lane, a);
        end
        if (!hold) cs[lane] = 1'b0;
    endtask

    task automatic collect_all(input rom_data_t key);
        logic [N_SLOTS-1:0] seen;
        int                 n;
        seen = '0;
        n    = 0;
        while (seen != '1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            for (int i = 0; i < N_SLOTS; i++) begin
                if (!seen[i] && ok[i] === 1'b1) begin
                    seen[i] = 1'b1;
                    check_data(dout[i], expected_word(addr[i], key),
                               $sformatf("dout[%0d] at %h", i, addr[i]));
                end
            end
        end
        for (int i = 0; i < N_SLOTS; i++) begin
            if (!seen[i]) begin
                timeouts++;
                $display("Timeout: slot %0d was starved, no ok within %0d cycles", i, TIMEOUT);
            end
        end
    endtask

    // All clients miss together, distinct addresses
    task automatic read_all(input rom_addr_t base, input rom_data_t key);
        for (int i = 0; i < N_SLOTS; i++) begin
            cs[i]   = 1'b1;
            addr[i] = (base + rom_addr_t'(i * 'h101)) & rom_addr_t'(MEM_WORDS - 1);
        end
        collect_all(key);
    endtask

    task automatic hold_and_change(input int lane, input rom_data_t key);
        rom_addr_t a;
        int        lat;
        a = rand_addr();
        read_slot(lane, a, key, 1'b1, lat);
        repeat (8) begin
            @(negedge clk);
            check_bit(ok[lane], 1'b1, "ok on held address");
            check_data(dout[lane], expected_word(a, key), "dout on held address");
        end
        addr[lane] = a ^ 16'h0800;
        #1;
        check_bit(ok[lane], 1'b0, "ok right after address change");
        @(negedge clk);
        read_slot(lane, a ^ 16'h0800, key, 1'b0, lat);
    endtask

    initial begin
        int lat;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        rst         = 1'b1;
        downloading = 1'b0;
        load_wr     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        cs          = '0;
        for (int i = 0; i < N_SLOTS; i++) addr[i] = '0;

        repeat (16) @(negedge clk);
        check_bit(rom_ready, 1'b0, "rom_ready in reset");
        rst = 1'b0;

        // Ready after reset, nothing valid yet
        wait_ready();
        repeat (2) @(negedge clk);  // Game reset chain
        cs = '1;  // Same address as the reset tag
        #1;
        for (int i = 0; i < N_SLOTS; i++) check_bit(ok[i], 1'b0, $sformatf("ok[%0d] idle", i));
        @(negedge clk);
        cs = '0;

        // Single client reads, slot by slot
        do_download(KEY_A);
        for (int r = 0; r < 3; r++) begin
            for (int lane = 0; lane < N_SLOTS; lane++) begin
                read_slot(lane, rand_addr(), KEY_A, 1'b0, lat);
                if (r == 0) check_bit(lat == RD_LATENCY + 2, 1'b1, "miss latency");
            end
        end

        read_all(rand_addr(), KEY_A);  // Contention, no starvation
        cs = '0;
        @(negedge clk);

        hold_and_change(1, KEY_A);
        @(negedge clk);

        // Reload under cached hits, old words must not come back
        read_all(rand_addr(), KEY_A);
        do_download(KEY_B);
        collect_all(KEY_B);
        cs = '0;
        @(negedge clk);
        for (int lane = 0; lane < N_SLOTS; lane++) begin
            read_slot(lane, rand_addr(), KEY_B, 1'b0, lat);
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rom_pkg.sv
rom_slot.sv
rom_arbiter.sv
rom_mem.sv
game_rom_top.sv
tb_game_rom.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_game_rom

.PHONY: all run clean

all: run

$(SIM): verilog.f rom_pkg.sv rom_slot.sv rom_arbiter.sv rom_mem.sv game_rom_top.sv tb_game_rom.sv
	verilator --binary --timing --assert -j 0 --top-module tb_game_rom \
		-f verilog.f -o Vtb_game_rom

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
